/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_lsu_miss_unit -f project.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_lsu_miss_unit > sim.log 2>&1; cat sim.log
	grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/bus_mem_model.sv */
`timescale 1ns/1ns

module bus_mem_model (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             slow_i,
  input  logic             bus_valid_i,
  input  logic             bus_write_i,
  input  lsu_pkg::addr_t   bus_addr_i,
  input  logic [3:0]       bus_burst_i,
  input  lsu_pkg::size_t   bus_size_i,
  input  lsu_pkg::word_t   bus_wdata_i,
  input  lsu_pkg::strobe_t bus_strobe_i,
  input  logic             bus_wvalid_i,
  input  logic             bus_wlast_i,
  output logic             bus_ready_o,
  output logic             bus_wready_o,
  output logic             bus_rvalid_o,
  output logic             bus_rlast_o,
  output lsu_pkg::word_t   bus_rdata_o
);
  import lsu_pkg::*;

  word_t       mem [256];   // loaded by the testbench
  logic [37:0] rd_log [$];  // addr, burst, size
  logic [68:0] wr_log [$];  // addr, wdata, strobe, wlast
  logic [1:0]  st;          // 0 idle, 1 write data, 2 read data
  addr_t       la;
  logic [7:0]  wa;
  logic [7:0]  beat;
  logic [7:0]  beats_m1;

  // heavy stalls when slow
  function automatic logic not_stalled();
    if (slow_i) return ($urandom % 8) == 0;
    return ($urandom % 4) != 0;
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t nw, strobe_t s);
    word_t r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = s[b] ? nw[8*b +: 8] : old[8*b +: 8];
    end
    return r;
  endfunction

  initial begin
    st           = 2'd0;
    bus_ready_o  = 1'b0;
    bus_wready_o = 1'b0;
    bus_rvalid_o = 1'b0;
    bus_rlast_o  = 1'b0;
    bus_rdata_o  = '0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        st = 2'd0;
      end else begin
        case (st)
          2'd0: if (bus_valid_i && bus_ready_o) begin
            la       = bus_addr_i;
            wa       = bus_addr_i[9:2];
            beat     = 8'd0;
            beats_m1 = {4'd0, bus_burst_i};
            if (bus_write_i) begin
              st = 2'd1;
            end else begin
              rd_log.push_back({bus_addr_i, bus_burst_i, bus_size_i});
              st = 2'd2;
            end
          end
          2'd1: if (bus_wvalid_i && bus_wready_o) begin
            mem[wa] = merge_bytes(mem[wa], bus_wdata_i, bus_strobe_i);
            wr_log.push_back({la, bus_wdata_i, bus_strobe_i, bus_wlast_i});
            st = 2'd0;
          end
          2'd2: if (bus_rvalid_o) begin
            st   = bus_rlast_o ? 2'd0 : 2'd2;
            beat = beat + 8'd1;
          end
          default: st = 2'd0;
        endcase
      end
      #2;
      bus_ready_o  = (st == 2'd0) && not_stalled();
      bus_wready_o = (st == 2'd1) && not_stalled();
      bus_rvalid_o = (st == 2'd2) && not_stalled();
      bus_rlast_o  = bus_rvalid_o && (beat == beats_m1);
      bus_rdata_o  = bus_rvalid_o ? mem[wa + beat] : '0;  // burst walks up the line
    end
  end

endmodule

/* bench/tb_lsu_miss_unit.sv */
`timescale 1ns/1ns

module tb_lsu_miss_unit;
  import lsu_pkg::*;

  localparam int N_RD  = 8;
  localparam int N_RF  = 6;
  localparam int N_WR  = 6;
  localparam int N_OPS = N_RD + N_RF + 2 * N_WR + 9;
  localparam int CYCLE = 40;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       req_i;
  op_kind_e   op_i;
  addr_t      addr_i;
  size_t      size_i;
  word_t      wdata_i;
  strobe_t    strobe_i;
  logic       ack_o;
  word_t      rdata_o;
  line_t      line_o;
  logic       bus_valid_o, bus_write_o, bus_wvalid_o, bus_wlast_o;
  addr_t      bus_addr_o;
  logic [3:0] bus_burst_o;
  size_t      bus_size_o;
  word_t      bus_wdata_o;
  strobe_t    bus_strobe_o;
  logic       bus_ready_i, bus_wready_i, bus_rvalid_i, bus_rlast_i;
  word_t      bus_rdata_i;
  logic       slow;

  word_t       shadow [256];
  word_t       exp_word [$];
  line_t       exp_line [$];
  logic [37:0] rd_exp [$];
  logic [68:0] wr_exp [$];
  op_kind_e    cur_kind = OP_UNC_WRITE;
  logic        ack_d;
  logic        saw_full = 1'b0;
  int          n_checks = 0;
  int          n_err = 0;
  int          n_tests = 0;

  lsu_miss_unit #(.WBUF_DEPTH(4)) u_dut (.*);

  bus_mem_model u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .slow_i       (slow),
    .bus_valid_i  (bus_valid_o),
    .bus_write_i  (bus_write_o),
    .bus_addr_i   (bus_addr_o),
    .bus_burst_i  (bus_burst_o),
    .bus_size_i   (bus_size_o),
    .bus_wdata_i  (bus_wdata_o),
    .bus_strobe_i (bus_strobe_o),
    .bus_wvalid_i (bus_wvalid_o),
    .bus_wlast_i  (bus_wlast_o),
    .bus_ready_o  (bus_ready_i),
    .bus_wready_o (bus_wready_i),
    .bus_rvalid_o (bus_rvalid_i),
    .bus_rlast_o  (bus_rlast_i),
    .bus_rdata_o  (bus_rdata_i)
  );

  always #20 clk = ~clk;

  // fixed mix of the byte address
  function automatic word_t init_word(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic word_t merge_word(word_t old, word_t nw, strobe_t s);
    word_t m;
    m = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return (old & ~m) | (nw & m);
  endfunction

  function automatic line_t line_ref(addr_t a);
    line_t l;
    for (int w = 0; w < LINE_WORDS; w++) begin
      l[w] = shadow[{a[9:4], w[1:0]}];
    end
    return l;
  endfunction

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("test %0d (%s) finished, %0d errors so far", n_tests, name, n_err);
  endtask

  // one four-phase operation, expected results queued as it is issued
  task automatic run_op(input op_kind_e k, input addr_t a, input size_t s,
                        input word_t d, input strobe_t b);
    logic [7:0] wi;
    wi = a[9:2];
    cur_kind = k;
    case (k)
      OP_UNC_WRITE: begin
        shadow[wi] = merge_word(shadow[wi], d, b);
        wr_exp.push_back({a, d, b, 1'b1});
      end
      OP_UNC_READ: begin
        exp_word.push_back(shadow[wi]);
        rd_exp.push_back({a, BURST_SINGLE, s});
      end
      default: begin
        exp_word.push_back(shadow[wi]);  // the word the request named
        exp_line.push_back(line_ref(a));
        rd_exp.push_back({a[31:4], 4'b0000, BURST_LINE, SIZE_WORD});
      end
    endcase
    op_i     = k;
    addr_i   = a;
    size_i   = s;
    wdata_i  = d;
    strobe_i = b;
    req_i    = 1'b1;
    @(posedge clk);
    while (!ack_o) @(posedge clk);
    #2 req_i = 1'b0;
    @(posedge clk);
    while (ack_o) @(posedge clk);
    #2;
  endtask

  // read results at the rising ack
  always @(posedge clk) begin
    if (ack_o && !ack_d && cur_kind != OP_UNC_WRITE) begin
      check(128'(rdata_o), 128'(exp_word.pop_front()), "rdata");
      if (cur_kind == OP_REFILL) check(line_o, exp_line.pop_front(), "line");
      check(128'(u_mem.rd_log.size()), 128'(rd_exp.size()), "bus read count");
      check(128'(u_mem.rd_log[u_mem.rd_log.size() - 1]),
            128'(rd_exp[rd_exp.size() - 1]), "bus read");
    end
    ack_d <= ack_o;
  end

  always @(posedge clk) begin
    if (u_dut.u_wbuf.full) saw_full <= 1'b1;
  end

  initial begin
    #(CYCLE * (400 * N_OPS + 20));
    $display("timeout: an operation was never acked");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    addr_t a;
    void'($urandom(32'h199e_52d2));
    rst_n    = 1'b0;
    req_i    = 1'b0;
    op_i     = OP_UNC_WRITE;
    addr_i   = '0;
    size_i   = '0;
    wdata_i  = '0;
    strobe_i = '0;
    slow     = 1'b0;
    for (int i = 0; i < 256; i++) begin
      shadow[i]     = init_word({22'd0, i[7:0], 2'b00});
      u_mem.mem[i]  = shadow[i];
    end

    for (int c = 0; c < 8; c++) begin
      @(posedge clk);
      #2;
      check(128'({ack_o, bus_valid_o, bus_wvalid_o}), '0, "outputs around reset");
      if (c == 4) rst_n = 1'b1;
    end
    end_test("reset");

    for (int n = 0; n < N_RD; n++) begin
      a = $urandom & 32'h0000_03fc;
      run_op(OP_UNC_READ, a, size_t'($urandom % 3), '0, '0);
    end
    end_test("uncached reads");

    for (int n = 0; n < N_RF; n++) begin
      run_op(OP_REFILL, $urandom & 32'h0000_03ff, 2'b00, '0, '0);
    end
    end_test("refills");

    for (int n = 0; n < N_WR; n++) begin
      a = $urandom & 32'h0000_03fc;
      run_op(OP_UNC_WRITE, a, SIZE_WORD, $urandom, strobe_t'($urandom));
      run_op(OP_UNC_READ, a, SIZE_WORD, '0, '0);
    end
    end_test("write then read");

    slow = 1'b1;
    a = $urandom & 32'h0000_03f0;
    for (int n = 0; n < 8; n++) begin
      run_op(OP_UNC_WRITE, a + 4 * (n % 4), SIZE_WORD, $urandom, strobe_t'($urandom));
    end
    run_op(OP_REFILL, a, SIZE_WORD, '0, '0);  // waits for the drain
    slow = 1'b0;
    check(128'(saw_full), 128'(1), "write buffer reached full");
    check(128'(u_mem.wr_log.size()), 128'(wr_exp.size()), "bus write count");
    foreach (wr_exp[i]) begin
      check(128'(u_mem.wr_log[i]), 128'(wr_exp[i]), "bus write");
    end
    end_test("stalled write burst");

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_err);
    if (n_err == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* logic/lsu_miss_unit.sv */
`timescale 1ns/1ns

module lsu_miss_unit #(
  parameter int WBUF_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  lsu_pkg::op_kind_e op_i,
  input  lsu_pkg::addr_t    addr_i,
  input  lsu_pkg::size_t    size_i,
  input  lsu_pkg::word_t    wdata_i,
  input  lsu_pkg::strobe_t  strobe_i,
  output logic              ack_o,
  output lsu_pkg::word_t    rdata_o,
  output lsu_pkg::line_t    line_o,
  output logic              bus_valid_o,
  output logic              bus_write_o,
  output lsu_pkg::addr_t    bus_addr_o,
  output logic [3:0]        bus_burst_o,
  output lsu_pkg::size_t    bus_size_o,
  output lsu_pkg::word_t    bus_wdata_o,
  output lsu_pkg::strobe_t  bus_strobe_o,
  output logic              bus_wvalid_o,
  output logic              bus_wlast_o,
  input  logic              bus_ready_i,
  input  logic              bus_wready_i,
  input  logic              bus_rvalid_i,
  input  logic              bus_rlast_i,
  input  lsu_pkg::word_t    bus_rdata_i
);
  import lsu_pkg::*;

  miss_op_if op_bus ();

  logic       wbuf_busy;
  logic       wbuf_valid, wbuf_write, wbuf_wvalid;
  addr_t      wbuf_addr;
  size_t      wbuf_size;
  word_t      wbuf_wdata;
  strobe_t    wbuf_strobe;
  logic       beat;
  logic [1:0] beat_idx;

  // only one sink pulses per operation
  assign op_bus.done = op_bus.rd_done | op_bus.wr_done;

  miss_op_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (req_i),
    .op_i     (op_i),
    .addr_i   (addr_i),
    .size_i   (size_i),
    .wdata_i  (wdata_i),
    .strobe_i (strobe_i),
    .ack_o    (ack_o),
    .op       (op_bus.decode_mp)
  );

  uncached_write_buffer #(
    .WBUF_DEPTH (WBUF_DEPTH)
  ) u_wbuf (
    .clk          (clk),
    .rst_n        (rst_n),
    .op           (op_bus.wbuf_mp),
    .wbuf_busy_o  (wbuf_busy),
    .bus_valid_o  (wbuf_valid),
    .bus_write_o  (wbuf_write),
    .bus_addr_o   (wbuf_addr),
    .bus_size_o   (wbuf_size),
    .bus_wdata_o  (wbuf_wdata),
    .bus_strobe_o (wbuf_strobe),
    .bus_wvalid_o (wbuf_wvalid),
    .bus_ready_i  (bus_ready_i),
    .bus_wready_i (bus_wready_i)
  );

  miss_bus_fsm u_exec (
    .clk           (clk),
    .rst_n         (rst_n),
    .op            (op_bus.exec_mp),
    .wbuf_busy_i   (wbuf_busy),
    .wbuf_valid_i  (wbuf_valid),
    .wbuf_write_i  (wbuf_write),
    .wbuf_addr_i   (wbuf_addr),
    .wbuf_size_i   (wbuf_size),
    .wbuf_wdata_i  (wbuf_wdata),
    .wbuf_strobe_i (wbuf_strobe),
    .wbuf_wvalid_i (wbuf_wvalid),
    .bus_valid_o   (bus_valid_o),
    .bus_write_o   (bus_write_o),
    .bus_addr_o    (bus_addr_o),
    .bus_burst_o   (bus_burst_o),
    .bus_size_o    (bus_size_o),
    .bus_wdata_o   (bus_wdata_o),
    .bus_strobe_o  (bus_strobe_o),
    .bus_wvalid_o  (bus_wvalid_o),
    .bus_wlast_o   (bus_wlast_o),
    .bus_ready_i   (bus_ready_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rlast_i   (bus_rlast_i),
    .beat_o        (beat),
    .beat_idx_o    (beat_idx)
  );

  refill_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .op          (op_bus.result_mp),
    .beat_i      (beat),
    .beat_idx_i  (beat_idx),
    .bus_rdata_i (bus_rdata_i),
    .line_o      (line_o),
    .rdata_o     (rdata_o)
  );

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strobe_t;
  typedef logic [1:0]  size_t;

  localparam size_t SIZE_WORD = 2'b10;

  localparam int LINE_WORDS = 4;
  typedef word_t [LINE_WORDS-1:0] line_t;  // 128 bits

  // burst length codes, beats minus one
  localparam logic [3:0] BURST_LINE   = 4'd3;
  localparam logic [3:0] BURST_SINGLE = 4'd0;

  typedef enum logic [1:0] {
    OP_UNC_WRITE = 2'd0,
    OP_UNC_READ  = 2'd1,
    OP_REFILL    = 2'd2
  } op_kind_e;

  // execute stage
  typedef enum logic [2:0] {
    M_IDLE      = 3'd0,
    M_WAIT_WBUF = 3'd1,
    M_RD_ADDR   = 3'd2,
    M_RD_DATA   = 3'd3,
    M_DONE      = 3'd4
  } miss_state_e;

  // write buffer drain
  typedef enum logic [1:0] {
    W_EMPTY = 2'd0,
    W_ADDR  = 2'd1,
    W_DATA  = 2'd2
  } wbuf_state_e;

endpackage

/* logic/miss_bus_fsm.sv */
`timescale 1ns/1ns

module miss_bus_fsm (
  input  logic             clk,
  input  logic             rst_n,
  miss_op_if.exec_mp       op,
  input  logic             wbuf_busy_i,
  input  logic             wbuf_valid_i,
  input  logic             wbuf_write_i,
  input  lsu_pkg::addr_t   wbuf_addr_i,
  input  lsu_pkg::size_t   wbuf_size_i,
  input  lsu_pkg::word_t   wbuf_wdata_i,
  input  lsu_pkg::strobe_t wbuf_strobe_i,
  input  logic             wbuf_wvalid_i,
  output logic             bus_valid_o,
  output logic             bus_write_o,
  output lsu_pkg::addr_t   bus_addr_o,
  output logic [3:0]       bus_burst_o,
  output lsu_pkg::size_t   bus_size_o,
  output lsu_pkg::word_t   bus_wdata_o,
  output lsu_pkg::strobe_t bus_strobe_o,
  output logic             bus_wvalid_o,
  output logic             bus_wlast_o,
  input  logic             bus_ready_i,
  input  logic             bus_rvalid_i,
  input  logic             bus_rlast_i,
  output logic             beat_o,
  output logic [1:0]       beat_idx_o
);
  import lsu_pkg::*;

  miss_state_e state_q, state_d;
  logic [1:0]  beat_cnt_q;
  logic        rd_req;
  logic        last_beat;

  assign rd_req    = op.valid && (op.kind != OP_UNC_WRITE);
  assign last_beat = (state_q == M_RD_DATA) && bus_rvalid_i && bus_rlast_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= M_IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == M_RD_ADDR && bus_ready_i) beat_cnt_q <= '0;
      else if (state_q == M_RD_DATA && bus_rvalid_i) beat_cnt_q <= beat_cnt_q + 2'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      M_IDLE: begin
        if (rd_req) begin
          // pending writes go first to keep program order
          state_d = wbuf_busy_i ? M_WAIT_WBUF : M_RD_ADDR;
        end
      end
      M_WAIT_WBUF: if (!wbuf_busy_i) state_d = M_RD_ADDR;
      M_RD_ADDR:   if (bus_ready_i) state_d = M_RD_DATA;
      M_RD_DATA:   if (last_beat) state_d = M_DONE;
      M_DONE:      state_d = M_IDLE;  // valid drops here
      default:     state_d = M_IDLE;
    endcase
  end

  assign op.rd_done  = last_beat;
  assign beat_o      = (state_q == M_RD_DATA) && bus_rvalid_i;
  assign beat_idx_o  = beat_cnt_q;

  // bus mux, write buffer owns the bus while busy
  always_comb begin
    if (wbuf_busy_i) begin
      bus_valid_o  = wbuf_valid_i;
      bus_write_o  = wbuf_write_i;
      bus_addr_o   = wbuf_addr_i;
      bus_burst_o  = BURST_SINGLE;
      bus_size_o   = wbuf_size_i;
      bus_wdata_o  = wbuf_wdata_i;
      bus_strobe_o = wbuf_strobe_i;
      bus_wvalid_o = wbuf_wvalid_i;
      bus_wlast_o  = wbuf_wvalid_i;
    end else begin
      bus_valid_o  = state_q == M_RD_ADDR;
      bus_write_o  = 1'b0;
      // refill burst starts at the line base
      bus_addr_o   = (op.kind == OP_REFILL) ? {op.addr[31:4], 4'b0000} : op.addr;
      bus_burst_o  = (op.kind == OP_REFILL) ? BURST_LINE : BURST_SINGLE;
      bus_size_o   = op.size;
      bus_wdata_o  = '0;
      bus_strobe_o = '0;
      bus_wvalid_o = 1'b0;
      bus_wlast_o  = 1'b0;
    end
  end

endmodule

/* logic/miss_op_decode.sv */
`timescale 1ns/1ns

module miss_op_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  lsu_pkg::op_kind_e op_i,
  input  lsu_pkg::addr_t    addr_i,
  input  lsu_pkg::size_t    size_i,
  input  lsu_pkg::word_t    wdata_i,
  input  lsu_pkg::strobe_t  strobe_i,
  output logic              ack_o,
  miss_op_if.decode_mp      op
);
  import lsu_pkg::*;

  logic     valid_q;
  logic     ack_q;
  op_kind_e kind_q;
  addr_t    addr_q;
  size_t    size_q;
  word_t    wdata_q;
  strobe_t  strobe_q;
  logic     capture;

  // new request only once the previous handshake has closed
  assign capture = req_i && !valid_q && !ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      if (capture) valid_q <= 1'b1;
      else if (op.done) valid_q <= 1'b0;

      if (op.done) ack_q <= 1'b1;
      else if (!req_i) ack_q <= 1'b0;  // four-phase return to zero
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      kind_q   <= op_i;
      wdata_q  <= wdata_i;
      strobe_q <= strobe_i;
      addr_q   <= addr_i;  // word offset kept for the result stage
      if (op_i == OP_REFILL) begin
        size_q <= SIZE_WORD;
      end else begin
        size_q <= size_i;
      end
    end
  end

  assign op.valid  = valid_q;
  assign op.kind   = kind_q;
  assign op.addr   = addr_q;
  assign op.size   = size_q;
  assign op.wdata  = wdata_q;
  assign op.strobe = strobe_q;
  assign ack_o     = ack_q;

endmodule

/* logic/miss_op_if.sv */
`timescale 1ns/1ns

interface miss_op_if;
  import lsu_pkg::*;

  logic     valid;
  op_kind_e kind;
  addr_t    addr;
  size_t    size;
  word_t    wdata;
  strobe_t  strobe;
  logic     rd_done;  // from execute stage
  logic     wr_done;  // from write buffer
  logic     done;     // merged at top level

  modport decode_mp (output valid, kind, addr, size, wdata, strobe, input done);
  modport exec_mp   (input valid, kind, addr, size, output rd_done);
  modport wbuf_mp   (input valid, kind, addr, size, wdata, strobe, output wr_done);
  modport result_mp (input kind, addr);

endinterface

/* logic/refill_result.sv */
`timescale 1ns/1ns

module refill_result (
  input  logic           clk,
  input  logic           rst_n,
  miss_op_if.result_mp   op,
  input  logic           beat_i,
  input  logic [1:0]     beat_idx_i,
  input  lsu_pkg::word_t bus_rdata_i,
  output lsu_pkg::line_t line_o,
  output lsu_pkg::word_t rdata_o
);
  import lsu_pkg::*;

  line_t      line_q;
  word_t      rdata_q;
  logic [1:0] slot;
  logic [1:0] req_word;

  assign req_word = op.addr[3:2];

  // uncached read lands on the addressed word
  assign slot = (op.kind == OP_UNC_READ) ? req_word : beat_idx_i;

  always_ff @(posedge clk) begin
    if (beat_i) line_q[slot] <= bus_rdata_i;
  end

  // requested word, caught as its beat goes by
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (beat_i && slot == req_word) begin
      rdata_q <= bus_rdata_i;
    end
  end

  assign line_o  = line_q;
  assign rdata_o = rdata_q;

endmodule

/* logic/uncached_write_buffer.sv */
`timescale 1ns/1ns

module uncached_write_buffer #(
  parameter int WBUF_DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  miss_op_if.wbuf_mp       op,
  output logic             wbuf_busy_o,
  output logic             bus_valid_o,
  output logic             bus_write_o,
  output lsu_pkg::addr_t   bus_addr_o,
  output lsu_pkg::size_t   bus_size_o,
  output lsu_pkg::word_t   bus_wdata_o,
  output lsu_pkg::strobe_t bus_strobe_o,
  output logic             bus_wvalid_o,
  input  logic             bus_ready_i,
  input  logic             bus_wready_i
);
  import lsu_pkg::*;

  localparam int PTR_W = $clog2(WBUF_DEPTH);

  addr_t   addr_mem   [WBUF_DEPTH];
  size_t   size_mem   [WBUF_DEPTH];
  word_t   wdata_mem  [WBUF_DEPTH];
  strobe_t strobe_mem [WBUF_DEPTH];

  logic [PTR_W:0] wr_ptr_q, rd_ptr_q;  // msb is the wrap bit
  logic [PTR_W:0] rd_ptr_nxt;
  logic           empty, full;
  logic           push, pop;
  logic           done_q;

  wbuf_state_e state_q, state_d;

  assign empty      = wr_ptr_q == rd_ptr_q;
  assign full       = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                      (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign rd_ptr_nxt = rd_ptr_q + 1'b1;

  // done_q blocks a second push while valid is still up
  assign push = op.valid && (op.kind == OP_UNC_WRITE) && !full && !done_q;
  assign pop  = (state_q == W_DATA) && bus_wready_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      done_q   <= 1'b0;
      state_q  <= W_EMPTY;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_nxt;
      done_q  <= push;
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr_q[PTR_W-1:0]]   <= op.addr;
      size_mem[wr_ptr_q[PTR_W-1:0]]   <= op.size;
      wdata_mem[wr_ptr_q[PTR_W-1:0]]  <= op.wdata;
      strobe_mem[wr_ptr_q[PTR_W-1:0]] <= op.strobe;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      W_EMPTY: if (!empty) state_d = W_ADDR;
      W_ADDR:  if (bus_ready_i) state_d = W_DATA;
      W_DATA: begin
        if (bus_wready_i) begin
          // straight to the next entry if one is waiting
          state_d = (rd_ptr_nxt == wr_ptr_q) ? W_EMPTY : W_ADDR;
        end
      end
      default: state_d = W_EMPTY;
    endcase
  end

  assign op.wr_done   = done_q;
  assign wbuf_busy_o  = !empty || (state_q != W_EMPTY);

  assign bus_valid_o  = state_q == W_ADDR;
  assign bus_write_o  = state_q == W_ADDR;
  assign bus_addr_o   = addr_mem[rd_ptr_q[PTR_W-1:0]];
  assign bus_size_o   = size_mem[rd_ptr_q[PTR_W-1:0]];
  assign bus_wdata_o  = wdata_mem[rd_ptr_q[PTR_W-1:0]];
  assign bus_strobe_o = strobe_mem[rd_ptr_q[PTR_W-1:0]];
  assign bus_wvalid_o = state_q == W_DATA;  // single beat, also the last

endmodule

/* project.f */
logic/lsu_pkg.sv
logic/miss_op_if.sv
logic/miss_op_decode.sv
logic/uncached_write_buffer.sv
logic/miss_bus_fsm.sv
logic/refill_result.sv
logic/lsu_miss_unit.sv
bench/bus_mem_model.sv
bench/tb_lsu_miss_unit.sv
